// ==== logic/spin_debug_defines.svh ====
/*
 * spin debug path sizing
 * array size, per-spin bitline width and step counter width
 */
`ifndef SPIN_DEBUG_DEFINES_SVH
`define SPIN_DEBUG_DEFINES_SVH

// spins in the array
`define SPIN_NUM 8

// bits per spin on the write bitlines, also the width of one read tally
`define SPIN_BITDATA 4

// cycle count and read number width
`define SPIN_CNT_W 8

`endif

// ==== logic/spin_debug_pkg.sv ====
/*
 * spin debug shared types
 * granted operation and sequencer phase encodings
 */
package spin_debug_pkg;

    // operation granted by the decoder
    typedef enum logic [1:0] {
        OP_NONE     = 2'd0,
        OP_WRITE    = 2'd1,
        OP_FEEDBACK = 2'd2,
        OP_READ     = 2'd3
    } dbg_op_e;

    // phase currently driven onto the array
    typedef enum logic [1:0] {
        PH_IDLE     = 2'd0,
        PH_WRITE    = 2'd1,
        PH_FEEDBACK = 2'd2,
        PH_READ     = 2'd3
    } seq_phase_e;

endpackage

// ==== logic/spin_phase_if.sv ====
/*
 * spin phase bus
 * start/op from the decoder, busy and read timing from the sequencer
 */
`timescale 1ns/1ps

interface spin_phase_if;
    import spin_debug_pkg::*;

    logic    start;
    dbg_op_e op;
    logic    busy;
    logic    read_strobe;
    logic    read_first;
    logic    read_last;

    modport decode (
        output start,
        output op,
        input  busy
    );

    modport sequencer (
        input  start,
        input  op,
        output busy,
        output read_strobe,
        output read_first,
        output read_last
    );

    modport capture (
        input read_strobe,
        input read_first,
        input read_last
    );

endinterface

// ==== logic/step_counter.sv ====
/*
 * step counter with a loadable limit
 * maxed_o flags the last step before the limit is reached
 */
`timescale 1ns/1ps
`include "spin_debug_defines.svh"

module step_counter (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  logic                   load_i,
    input  logic                   clear_i,
    input  logic                   step_i,
    input  logic [`SPIN_CNT_W-1:0] limit_i,
    output logic                   maxed_o
);
    localparam int CNT_W = `SPIN_CNT_W;

    logic [CNT_W-1:0] limit_q;
    logic [CNT_W-1:0] count_q;
    logic [CNT_W-1:0] count_inc;

    assign count_inc = count_q + CNT_W'(1);

    // high during the final step cycle
    assign maxed_o = (count_inc == limit_q);

    // limit register, defaults to a single step
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            limit_q <= CNT_W'(1);
        end else if (load_i) begin
            limit_q <= limit_i;
        end
    end

    // clear wins over step
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            count_q <= '0;
        end else if (clear_i) begin
            count_q <= '0;
        end else if (step_i) begin
            count_q <= count_inc;
        end
    end

endmodule

// ==== logic/spin_cmd_decode.sv ====
/*
 * debug request decoder
 * fixed priority write > feedback > read, one start pulse per grant
 */
`timescale 1ns/1ps

module spin_cmd_decode (
    input  logic         clk_i,
    input  logic         rst_n_i,
    input  logic         en_i,
    input  logic         debug_wen_i,
    input  logic         debug_feedback_en_i,
    input  logic         debug_ren_i,
    spin_phase_if.decode ph
);
    import spin_debug_pkg::*;

    logic    grant_ok;
    logic    granted_q;
    dbg_op_e op_sel;

    // path free to accept a new request
    // granted_q covers the cycle before busy rises
    assign grant_ok = en_i & ~ph.busy & ~granted_q;

    always_comb begin
        op_sel = OP_NONE;
        if (grant_ok) begin
            if (debug_wen_i) begin
                op_sel = OP_WRITE;
            end else if (debug_feedback_en_i) begin
                op_sel = OP_FEEDBACK;
            end else if (debug_ren_i) begin
                op_sel = OP_READ;
            end
        end
    end

    assign ph.start = (op_sel != OP_NONE);
    assign ph.op    = op_sel;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            granted_q <= 1'b0;
        end else begin
            granted_q <= ph.start;
        end
    end

endmodule

// ==== logic/spin_phase_sequencer.sv ====
/*
 * spin phase sequencer
 * runs timed write, feedback and read phases and gates the array drives
 */
`timescale 1ns/1ps
`include "spin_debug_defines.svh"

module spin_phase_sequencer (
    input  logic                                  clk_i,
    input  logic                                  rst_n_i,
    input  logic                                  en_i,
    input  logic                                  cfg_load_i,
    input  logic [`SPIN_CNT_W-1:0]                cycle_per_write_i,
    input  logic [`SPIN_CNT_W-1:0]                cycle_per_compute_i,
    input  logic [`SPIN_CNT_W-1:0]                cycle_per_read_i,
    input  logic [`SPIN_CNT_W-1:0]                read_num_i,
    input  logic [`SPIN_NUM-1:0]                  wwl_strobe_i,
    input  logic [`SPIN_NUM-1:0]                  feedback_mask_i,
    input  logic [`SPIN_NUM*`SPIN_BITDATA-1:0]    wbl_data_i,
    spin_phase_if.sequencer                       ph,
    output logic [`SPIN_NUM-1:0]                  spin_wwl_o,
    output logic [`SPIN_NUM-1:0]                  spin_feedback_o,
    output logic [`SPIN_NUM*`SPIN_BITDATA-1:0]    wbl_spin_o,
    output logic [`SPIN_NUM*`SPIN_BITDATA-1:0]    wblb_spin_o,
    output spin_debug_pkg::seq_phase_e            phase_o
);
    import spin_debug_pkg::*;

    logic                               cfg_load;
    logic                               start_q;
    dbg_op_e                            op_q;
    seq_phase_e                         phase_q;
    seq_phase_e                         phase_d;
    logic                               wr_maxed;
    logic                               cmp_maxed;
    logic                               rc_maxed;
    logic                               rn_maxed;
    logic                               rd_strobe;
    logic                               strobe_seen_q;
    logic [`SPIN_NUM-1:0]               wwl_strobe_q;
    logic [`SPIN_NUM-1:0]               feedback_mask_q;
    logic [`SPIN_NUM*`SPIN_BITDATA-1:0] wbl_data_q;

    assign cfg_load = cfg_load_i & en_i;

    // configuration payload
    always_ff @(posedge clk_i) begin
        if (cfg_load) begin
            wwl_strobe_q    <= wwl_strobe_i;
            feedback_mask_q <= feedback_mask_i;
            wbl_data_q      <= wbl_data_i;
        end
    end

    // phase timers, held at zero outside their phase
    step_counter u_write_cnt (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .load_i  (cfg_load),
        .clear_i (phase_q != PH_WRITE),
        .step_i  (phase_q == PH_WRITE),
        .limit_i (cycle_per_write_i),
        .maxed_o (wr_maxed)
    );

    step_counter u_compute_cnt (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .load_i  (cfg_load),
        .clear_i (phase_q != PH_FEEDBACK),
        .step_i  (phase_q == PH_FEEDBACK),
        .limit_i (cycle_per_compute_i),
        .maxed_o (cmp_maxed)
    );

    // read window timer wraps every R cycles
    step_counter u_read_cyc_cnt (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .load_i  (cfg_load),
        .clear_i ((phase_q != PH_READ) | rc_maxed),
        .step_i  (phase_q == PH_READ),
        .limit_i (cycle_per_read_i),
        .maxed_o (rc_maxed)
    );

    // one step per read strobe
    step_counter u_read_num_cnt (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .load_i  (cfg_load),
        .clear_i (phase_q != PH_READ),
        .step_i  (rd_strobe),
        .limit_i (read_num_i),
        .maxed_o (rn_maxed)
    );

    assign rd_strobe      = (phase_q == PH_READ) & rc_maxed;
    assign ph.read_strobe = rd_strobe;
    assign ph.read_first  = rd_strobe & ~strobe_seen_q;
    assign ph.read_last   = rd_strobe & rn_maxed;
    assign ph.busy        = (phase_q != PH_IDLE);

    always_comb begin
        phase_d = phase_q;
        if (!en_i) begin
            phase_d = PH_IDLE;
        end else begin
            case (phase_q)
                PH_IDLE: begin
                    if (start_q) begin
                        case (op_q)
                            OP_WRITE:    phase_d = PH_WRITE;
                            OP_FEEDBACK: phase_d = PH_FEEDBACK;
                            OP_READ:     phase_d = PH_READ;
                            default:     phase_d = PH_IDLE;
                        endcase
                    end
                end
                PH_WRITE:    if (wr_maxed) phase_d = PH_IDLE;
                PH_FEEDBACK: if (cmp_maxed) phase_d = PH_IDLE;
                PH_READ:     if (ph.read_last) phase_d = PH_IDLE;
                default:     phase_d = PH_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            start_q       <= 1'b0;
            op_q          <= OP_NONE;
            phase_q       <= PH_IDLE;
            strobe_seen_q <= 1'b0;
        end else begin
            start_q <= ph.start & en_i;
            op_q    <= ph.op;
            phase_q <= phase_d;
            if (phase_q != PH_READ) begin
                strobe_seen_q <= 1'b0;
            end else if (rd_strobe) begin
                strobe_seen_q <= 1'b1;
            end
        end
    end

    // array drives, zero outside their phase
    assign spin_wwl_o      = (phase_q == PH_WRITE) ? wwl_strobe_q : '0;
    assign wbl_spin_o      = (phase_q == PH_WRITE) ? wbl_data_q : '0;
    assign wblb_spin_o     = (phase_q == PH_WRITE) ? ~wbl_data_q : '0;
    assign spin_feedback_o = ((phase_q == PH_FEEDBACK) || (phase_q == PH_READ)) ?
                             feedback_mask_q : '0;
    assign phase_o         = phase_q;

endmodule

// ==== logic/spin_read_capture.sv ====
/*
 * spin read capture
 * saturating per-spin count of sampled ones over a read burst
 */
`timescale 1ns/1ps
`include "spin_debug_defines.svh"

module spin_read_capture (
    input  logic                               clk_i,
    input  logic                               rst_n_i,
    input  logic [`SPIN_NUM-1:0]               spin_state_i,
    spin_phase_if.capture                      ph,
    output logic [`SPIN_NUM*`SPIN_BITDATA-1:0] read_tally_o,
    output logic                               read_valid_o
);
    localparam int BD = `SPIN_BITDATA;

    logic [`SPIN_NUM*BD-1:0] acc_q;
    logic [`SPIN_NUM*BD-1:0] acc_d;

    // next tally per spin, restarting on the first strobe
    always_comb begin
        logic [BD-1:0] base;
        acc_d = acc_q;
        for (int i = 0; i < `SPIN_NUM; i++) begin
            base = ph.read_first ? '0 : acc_q[i*BD +: BD];
            if (&base) begin
                acc_d[i*BD +: BD] = base;
            end else begin
                acc_d[i*BD +: BD] = base + BD'(spin_state_i[i]);
            end
        end
    end

    // running tallies, only meaningful inside a burst
    always_ff @(posedge clk_i) begin
        if (ph.read_strobe) begin
            acc_q <= acc_d;
        end
    end

    // burst result, held until the next burst ends
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            read_tally_o <= '0;
            read_valid_o <= 1'b0;
        end else begin
            read_valid_o <= ph.read_last;
            if (ph.read_last) begin
                read_tally_o <= acc_d;
            end
        end
    end

endmodule

// ==== logic/spin_debug_top.sv ====
/*
 * spin array debug path
 * request decode, phase sequencing and read-back tallies
 */
`timescale 1ns/1ps
`include "spin_debug_defines.svh"

module spin_debug_top (
    input  logic                               clk_i,
    input  logic                               rst_n_i,
    input  logic                               en_i,
    // configuration
    input  logic                               cfg_load_i,
    input  logic [`SPIN_CNT_W-1:0]             cycle_per_write_i,
    input  logic [`SPIN_CNT_W-1:0]             cycle_per_compute_i,
    input  logic [`SPIN_CNT_W-1:0]             cycle_per_read_i,
    input  logic [`SPIN_CNT_W-1:0]             read_num_i,
    input  logic [`SPIN_NUM-1:0]               wwl_strobe_i,
    input  logic [`SPIN_NUM-1:0]               feedback_mask_i,
    input  logic [`SPIN_NUM*`SPIN_BITDATA-1:0] wbl_data_i,
    // debug requests
    input  logic                               debug_wen_i,
    input  logic                               debug_feedback_en_i,
    input  logic                               debug_ren_i,
    // analog array
    input  logic [`SPIN_NUM-1:0]               spin_state_i,
    output logic [`SPIN_NUM-1:0]               spin_wwl_o,
    output logic [`SPIN_NUM-1:0]               spin_feedback_o,
    output logic [`SPIN_NUM*`SPIN_BITDATA-1:0] wbl_spin_o,
    output logic [`SPIN_NUM*`SPIN_BITDATA-1:0] wblb_spin_o,
    output logic                               read_sync_o,
    // read-back and status
    output logic [`SPIN_NUM*`SPIN_BITDATA-1:0] read_tally_o,
    output logic                               read_valid_o,
    output spin_debug_pkg::seq_phase_e         phase_o,
    output logic                               debug_idle_o,
    output logic                               debug_w_idle_o,
    output logic                               debug_feedback_idle_o,
    output logic                               debug_r_idle_o
);
    import spin_debug_pkg::*;

    spin_phase_if ph_bus ();

    spin_cmd_decode u_decode (
        .clk_i               (clk_i),
        .rst_n_i             (rst_n_i),
        .en_i                (en_i),
        .debug_wen_i         (debug_wen_i),
        .debug_feedback_en_i (debug_feedback_en_i),
        .debug_ren_i         (debug_ren_i),
        .ph                  (ph_bus.decode)
    );

    spin_phase_sequencer u_sequencer (
        .clk_i               (clk_i),
        .rst_n_i             (rst_n_i),
        .en_i                (en_i),
        .cfg_load_i          (cfg_load_i),
        .cycle_per_write_i   (cycle_per_write_i),
        .cycle_per_compute_i (cycle_per_compute_i),
        .cycle_per_read_i    (cycle_per_read_i),
        .read_num_i          (read_num_i),
        .wwl_strobe_i        (wwl_strobe_i),
        .feedback_mask_i     (feedback_mask_i),
        .wbl_data_i          (wbl_data_i),
        .ph                  (ph_bus.sequencer),
        .spin_wwl_o          (spin_wwl_o),
        .spin_feedback_o     (spin_feedback_o),
        .wbl_spin_o          (wbl_spin_o),
        .wblb_spin_o         (wblb_spin_o),
        .phase_o             (phase_o)
    );

    spin_read_capture u_capture (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .spin_state_i (spin_state_i),
        .ph           (ph_bus.capture),
        .read_tally_o (read_tally_o),
        .read_valid_o (read_valid_o)
    );

    // sample point for the array
    assign read_sync_o = ph_bus.read_strobe;

    // status decoded from the phase
    assign debug_idle_o          = (phase_o == PH_IDLE);
    assign debug_w_idle_o        = (phase_o != PH_WRITE);
    assign debug_feedback_idle_o = (phase_o != PH_FEEDBACK);
    assign debug_r_idle_o        = (phase_o != PH_READ);

endmodule

// ==== tests/spin_debug_clkgen.sv ====
/*
 * testbench clock and reset source
 */
`timescale 1ns/1ps

module spin_debug_clkgen #(
    parameter int PERIOD_NS    = 100,
    parameter int RESET_CYCLES = 4
) (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    // release just after an edge, like the other stimulus
    initial begin
        rst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        #1 rst_n_o = 1'b1;
    end

endmodule

// ==== tests/spin_debug_checker.sv ====
/*
 * spin debug protocol checker
 * bound to the top level, watches drive gating, status and read-back timing
 */
`timescale 1ns/1ps
`include "spin_debug_defines.svh"

module spin_debug_checker (
    input logic                       clk_i,
    input logic                       rst_n_i,
    input spin_debug_pkg::seq_phase_e phase_i,
    input logic [`SPIN_NUM-1:0]       spin_wwl_i,
    input logic                       debug_idle_i,
    input logic                       debug_w_idle_i,
    input logic                       debug_feedback_idle_i,
    input logic                       debug_r_idle_i,
    input logic                       read_sync_i,
    input logic                       read_valid_i
);
    import spin_debug_pkg::*;

    int assert_fail_cnt = 0;

    // wordlines strobe only while writing
    wwl_gated_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (phase_i != PH_WRITE) |-> (spin_wwl_i == '0))
        else begin
            assert_fail_cnt++;
            $error("wordline strobe active outside the write phase");
        end

    // exactly one status low or idle high, matching the phase
    idle_status_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $onehot({debug_idle_i, ~debug_w_idle_i, ~debug_feedback_idle_i, ~debug_r_idle_i})
        && (debug_idle_i == (phase_i == PH_IDLE))
        && (debug_w_idle_i == (phase_i != PH_WRITE))
        && (debug_feedback_idle_i == (phase_i != PH_FEEDBACK))
        && (debug_r_idle_i == (phase_i != PH_READ)))
        else begin
            assert_fail_cnt++;
            $error("idle outputs disagree with the phase");
        end

    // a burst result always comes right after a read strobe
    valid_after_sync_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        read_valid_i |-> $past(read_sync_i))
        else begin
            assert_fail_cnt++;
            $error("read valid without a preceding read strobe");
        end

endmodule

bind spin_debug_top spin_debug_checker u_checker (
    .clk_i                 (clk_i),
    .rst_n_i               (rst_n_i),
    .phase_i               (phase_o),
    .spin_wwl_i            (spin_wwl_o),
    .debug_idle_i          (debug_idle_o),
    .debug_w_idle_i        (debug_w_idle_o),
    .debug_feedback_idle_i (debug_feedback_idle_o),
    .debug_r_idle_i        (debug_r_idle_o),
    .read_sync_i           (read_sync_o),
    .read_valid_i          (read_valid_o)
);

// ==== tests/spin_debug_tb.sv ====
/*
 * spin debug path testbench
 * table-driven phases with a reference tally model and a watchdog
 */
`timescale 1ns/1ps
`include "spin_debug_defines.svh"

module spin_debug_tb;
    import spin_debug_pkg::*;

    localparam int PERIOD_NS = 100;
    localparam int SEED      = 23101;
    localparam int N_TESTS   = 8;
    localparam int NS        = `SPIN_NUM;
    localparam int BD        = `SPIN_BITDATA;
    localparam int CW        = `SPIN_CNT_W;
    localparam int TALLY_MAX = (1 << BD) - 1;

    typedef struct {
        string            name;
        logic             en;
        logic             load;
        logic [2:0]       req;        // write, feedback, read
        int               w;
        int               c;
        int               r;
        int               n;
        logic [NS-1:0]    wwl;
        logic [NS-1:0]    fb;
        logic [NS*BD-1:0] wbl;
        logic [NS-1:0]    force_ones; // spins that always read one
        int               exp_busy;
        seq_phase_e       exp_phase;
    } test_row_t;

    logic             clk;
    logic             rst_n;
    logic             en;
    logic             cfg_load;
    logic [CW-1:0]    cycle_per_write;
    logic [CW-1:0]    cycle_per_compute;
    logic [CW-1:0]    cycle_per_read;
    logic [CW-1:0]    read_num;
    logic [NS-1:0]    wwl_strobe;
    logic [NS-1:0]    feedback_mask;
    logic [NS*BD-1:0] wbl_data;
    logic             debug_wen;
    logic             debug_feedback_en;
    logic             debug_ren;
    logic [NS-1:0]    spin_state;
    logic [NS-1:0]    spin_wwl;
    logic [NS-1:0]    spin_feedback;
    logic [NS*BD-1:0] wbl_spin;
    logic [NS*BD-1:0] wblb_spin;
    logic             read_sync;
    logic [NS*BD-1:0] read_tally;
    logic             read_valid;
    seq_phase_e       phase;
    logic             debug_idle;
    logic             debug_w_idle;
    logic             debug_feedback_idle;
    logic             debug_r_idle;

    test_row_t   tests [N_TESTS];
    logic [31:0] rng_state;
    int          err_cnt = 0;
    int          wd_cycles = 0;
    // reference copy of the loaded configuration
    int               m_w = 1;
    int               m_c = 1;
    int               m_r = 1;
    int               m_n = 1;
    logic [NS-1:0]    m_wwl;
    logic [NS-1:0]    m_fb;
    logic [NS*BD-1:0] m_wbl;
    // per test tracking
    logic [2:0]  req_q;
    seq_phase_e  order [$];
    seq_phase_e  prev_phase;
    seq_phase_e  first_phase;
    int          seg_len;
    int          strobes;
    int          busy_cnt;
    logic        settled;
    int          ones_cnt [NS];

    spin_debug_clkgen #(.PERIOD_NS(PERIOD_NS), .RESET_CYCLES(4)) u_clkgen (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    spin_debug_top DUT (
        .clk_i                 (clk),
        .rst_n_i               (rst_n),
        .en_i                  (en),
        .cfg_load_i            (cfg_load),
        .cycle_per_write_i     (cycle_per_write),
        .cycle_per_compute_i   (cycle_per_compute),
        .cycle_per_read_i      (cycle_per_read),
        .read_num_i            (read_num),
        .wwl_strobe_i          (wwl_strobe),
        .feedback_mask_i       (feedback_mask),
        .wbl_data_i            (wbl_data),
        .debug_wen_i           (debug_wen),
        .debug_feedback_en_i   (debug_feedback_en),
        .debug_ren_i           (debug_ren),
        .spin_state_i          (spin_state),
        .spin_wwl_o            (spin_wwl),
        .spin_feedback_o       (spin_feedback),
        .wbl_spin_o            (wbl_spin),
        .wblb_spin_o           (wblb_spin),
        .read_sync_o           (read_sync),
        .read_tally_o          (read_tally),
        .read_valid_o          (read_valid),
        .phase_o               (phase),
        .debug_idle_o          (debug_idle),
        .debug_w_idle_o        (debug_w_idle),
        .debug_feedback_idle_o (debug_feedback_idle),
        .debug_r_idle_o        (debug_r_idle)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic int total_errors();
        return err_cnt + DUT.u_checker.assert_fail_cnt;
    endfunction

    // busy length of one phase under the loaded configuration
    function automatic int phase_len(input seq_phase_e p);
        case (p)
            PH_WRITE:    return m_w;
            PH_FEEDBACK: return m_c;
            PH_READ:     return m_n * m_r;
            default:     return 0;
        endcase
    endfunction

    function automatic logic [2:0] phase_req(input seq_phase_e p);
        case (p)
            PH_WRITE:    return 3'b100;
            PH_FEEDBACK: return 3'b010;
            PH_READ:     return 3'b001;
            default:     return 3'b000;
        endcase
    endfunction

    task automatic expect_eq(input logic [63:0] got, input logic [63:0] exp, input string what);
        assert (got === exp) else begin
            $display("MISMATCH at %0d ns: %s is %0h, expected %0h", $time, what, got, exp);
            err_cnt++;
        end
    endtask

    // one sample per cycle at the falling edge
    task automatic observe_cycle();
        seq_phase_e p;
        logic       exp_sync;
        int         exp_tally;
        p = phase;
        if (p != prev_phase) begin
            if (prev_phase != PH_IDLE) begin
                expect_eq(seg_len, phase_len(prev_phase),
                          $sformatf("%s length", prev_phase.name()));
                if (prev_phase == PH_READ) begin
                    expect_eq(strobes, m_n, "read strobe count");
                end
            end
            if (p != PH_IDLE) begin
                expect_eq(order.size() > 0, 1'b1, $sformatf("%s phase allowed", p.name()));
                if (order.size() > 0) begin
                    expect_eq(p, order.pop_front(), "phase order");
                end
                if (first_phase == PH_IDLE) begin
                    first_phase = p;
                end
                req_q   = req_q & ~phase_req(p);
                seg_len = 0;
                strobes = 0;
                if (p == PH_READ) begin
                    foreach (ones_cnt[i]) ones_cnt[i] = 0;
                end
            end
        end
        if (p != PH_IDLE) begin
            seg_len++;
            busy_cnt++;
        end
        expect_eq(spin_wwl, (p == PH_WRITE) ? m_wwl : '0, "spin_wwl_o");
        expect_eq(wbl_spin, (p == PH_WRITE) ? m_wbl : '0, "wbl_spin_o");
        expect_eq(wblb_spin, (p == PH_WRITE) ? (NS*BD)'(~m_wbl) : '0, "wblb_spin_o");
        expect_eq(spin_feedback, (p == PH_FEEDBACK || p == PH_READ) ? m_fb : '0,
                  "spin_feedback_o");
        expect_eq({debug_idle, debug_w_idle, debug_feedback_idle, debug_r_idle},
                  {p == PH_IDLE, p != PH_WRITE, p != PH_FEEDBACK, p != PH_READ},
                  "idle outputs");
        // strobe in the last cycle of each read window
        exp_sync = (p == PH_READ) && (seg_len % m_r == 0);
        expect_eq(read_sync, exp_sync, "read_sync_o");
        if (exp_sync) begin
            strobes++;
            for (int i = 0; i < NS; i++) ones_cnt[i] += spin_state[i];
        end
        expect_eq(read_valid, (prev_phase == PH_READ) && (p != PH_READ), "read_valid_o");
        if (read_valid) begin
            for (int i = 0; i < NS; i++) begin
                exp_tally = (ones_cnt[i] > TALLY_MAX) ? TALLY_MAX : ones_cnt[i];
                expect_eq(read_tally[i*BD +: BD], exp_tally, $sformatf("tally of spin %0d", i));
            end
        end
        prev_phase = p;
        settled    = (order.size() == 0) && (p == PH_IDLE);
    endtask

    task automatic run_test(input test_row_t t, input int idx, output logic ok);
        int errs_before;
        int cyc;
        errs_before = total_errors();
        @(posedge clk);
        #1;
        en                = t.en;
        debug_wen         = 1'b0;
        debug_feedback_en = 1'b0;
        debug_ren         = 1'b0;
        if (t.load) begin
            cycle_per_write   = CW'(t.w);
            cycle_per_compute = CW'(t.c);
            cycle_per_read    = CW'(t.r);
            read_num          = CW'(t.n);
            wwl_strobe        = t.wwl;
            feedback_mask     = t.fb;
            wbl_data          = t.wbl;
            cfg_load          = 1'b1;
        end
        // the DUT captures only while enabled
        if (t.load && t.en) begin
            m_w   = t.w;
            m_c   = t.c;
            m_r   = t.r;
            m_n   = t.n;
            m_wwl = t.wwl;
            m_fb  = t.fb;
            m_wbl = t.wbl;
        end
        @(posedge clk);
        #1;
        cfg_load = 1'b0;
        order.delete();
        if (t.en) begin
            if (t.req[2]) order.push_back(PH_WRITE);
            if (t.req[1]) order.push_back(PH_FEEDBACK);
            if (t.req[0]) order.push_back(PH_READ);
        end
        req_q       = t.req;
        prev_phase  = PH_IDLE;
        first_phase = PH_IDLE;
        busy_cnt    = 0;
        cyc         = 0;
        do begin
            debug_wen         = req_q[2];
            debug_feedback_en = req_q[1];
            debug_ren         = req_q[0];
            rng_state         = xorshift32(rng_state);
            spin_state        = rng_state[NS-1:0] | t.force_ones;
            @(negedge clk);
            observe_cycle();
            cyc++;
            @(posedge clk);
            #1;
        end while (!(cyc >= 8 && settled));
        expect_eq(busy_cnt, t.exp_busy, "busy cycles");
        expect_eq(first_phase, t.exp_phase, "first phase");
        ok = (total_errors() == errs_before);
        $display("test %0d %s %s  busy %0d cycles, %0d errors", idx, t.name,
                 ok ? "pass" : "FAIL", busy_cnt, total_errors() - errs_before);
    endtask

    initial begin
        logic ok;
        int   pass_cnt;
        int   fail_cnt;
        int   budget;
        en                = 1'b0;
        cfg_load          = 1'b0;
        cycle_per_write   = '0;
        cycle_per_compute = '0;
        cycle_per_read    = '0;
        read_num          = '0;
        wwl_strobe        = '0;
        feedback_mask     = '0;
        wbl_data          = '0;
        debug_wen         = 1'b0;
        debug_feedback_en = 1'b0;
        debug_ren         = 1'b0;
        spin_state        = '0;
        rng_state         = SEED;
        pass_cnt          = 0;
        fail_cnt          = 0;
        tests[0] = '{"write phase", 1'b1, 1'b1, 3'b100, 5, 3, 2, 3,
                     8'hA5, 8'h3C, 32'hDEAD_BEEF, 8'h00, 5, PH_WRITE};
        tests[1] = '{"feedback phase", 1'b1, 1'b0, 3'b010, 0, 0, 0, 0,
                     8'h00, 8'h00, 32'h0, 8'h00, 3, PH_FEEDBACK};
        tests[2] = '{"read burst", 1'b1, 1'b1, 3'b001, 5, 3, 3, 4,
                     8'h5A, 8'hC3, 32'h0123_4567, 8'h00, 12, PH_READ};
        tests[3] = '{"read saturation", 1'b1, 1'b1, 3'b001, 1, 1, 1, 20,
                     8'hFF, 8'h0F, 32'hFFFF_0000, 8'hF0, 20, PH_READ};
        tests[4] = '{"priority order", 1'b1, 1'b1, 3'b111, 2, 4, 2, 3,
                     8'h81, 8'h7E, 32'hA5A5_5A5A, 8'h00, 12, PH_WRITE};
        tests[5] = '{"disabled path", 1'b0, 1'b1, 3'b111, 9, 9, 9, 9,
                     8'hFF, 8'hFF, 32'hFFFF_FFFF, 8'h00, 0, PH_IDLE};
        tests[6] = '{"config kept", 1'b1, 1'b0, 3'b110, 0, 0, 0, 0,
                     8'h00, 8'h00, 32'h0, 8'h00, 6, PH_WRITE};
        tests[7] = '{"config reload", 1'b1, 1'b1, 3'b111, 7, 1, 4, 2,
                     8'h3C, 8'h99, 32'h1357_9BDF, 8'h0F, 16, PH_WRITE};
        // busy cycles plus setup and idle gaps per row
        budget = 30;
        foreach (tests[i]) budget += tests[i].exp_busy + 20;
        wd_cycles = budget;
        @(posedge rst_n);
        for (int i = 0; i < N_TESTS; i++) begin
            run_test(tests[i], i, ok);
            if (ok) pass_cnt++;
            else fail_cnt++;
        end
        $display("%0d tests: %0d passed, %0d failed, %0d errors", N_TESTS, pass_cnt,
                 fail_cnt, total_errors());
        if (fail_cnt == 0 && total_errors() == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // ends a hung run
    initial begin
        wait (wd_cycles > 0);
        repeat (wd_cycles) @(posedge clk);
        $display("watchdog expired after %0d cycles, the run did not finish", wd_cycles);
        $display("Test failed");
        $finish;
    end

endmodule

// ==== spin_debug.f ====
+incdir+logic
logic/spin_debug_pkg.sv
logic/spin_phase_if.sv
logic/step_counter.sv
logic/spin_cmd_decode.sv
logic/spin_phase_sequencer.sv
logic/spin_read_capture.sv
logic/spin_debug_top.sv
tests/spin_debug_clkgen.sv
tests/spin_debug_checker.sv
tests/spin_debug_tb.sv
